// File: hdl/cache_pkg.sv
package cache_pkg;

	localparam int ADDR_W      = 16;
	localparam int DATA_W      = 16;
	localparam int OFFSET_BITS = 3;   // Byte offset inside a four-word line

	// Host request, held stable until done
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              rd;
		logic              wr;
	} cache_req_t;

	// One word command per cycle toward main memory
	typedef struct packed {
		logic [ADDR_W-1:0] addr;   // Word aligned byte address
		logic [DATA_W-1:0] wdata;
		logic              rd;
		logic              wr;
	} mem_cmd_t;

	typedef enum logic [3:0] {
		IDLE          = 4'd0,
		WB0           = 4'd1,    // Victim writeback
		WB1           = 4'd2,
		WB2           = 4'd3,
		WB3           = 4'd4,
		FILL_REQ0     = 4'd5,    // Memory read requests
		FILL_REQ1     = 4'd6,
		FILL_REQ2_WR0 = 4'd7,    // Requests overlap with line writes
		FILL_REQ3_WR1 = 4'd8,
		FILL_WR2      = 4'd9,
		FILL_WR3      = 4'd10    // Last word, tag and valid set here
	} ctrl_state_t;

endpackage

// File: hdl/main_memory.sv
`timescale 1ns/10ps

module main_memory
	import cache_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  mem_cmd_t          mem_cmd,
	output logic [DATA_W-1:0] mem_rdata
);

	localparam int BANKS      = 4;
	localparam int BANK_WORDS = 1 << (ADDR_W - OFFSET_BITS);  // 8192 words per bank

	logic [DATA_W-1:0]             bank_mem [BANKS][BANK_WORDS];
	logic [1:0]                    bank_sel;
	logic [ADDR_W-OFFSET_BITS-1:0] word_idx;
	logic [DATA_W-1:0]             rd_stage1;
	logic [DATA_W-1:0]             rd_stage2;

	assign bank_sel = mem_cmd.addr[2:1];             // Word within the line picks the bank
	assign word_idx = mem_cmd.addr[ADDR_W-1:OFFSET_BITS];

	// Each word starts as the inverse of its own byte address
	initial begin
		for (int b = 0; b < BANKS; b++) begin
			for (int w = 0; w < BANK_WORDS; w++) begin
				bank_mem[b][w] = ~DATA_W'(w * 8 + b * 2);
			end
		end
	end

	always @(posedge clk) begin
		if (mem_cmd.wr) begin
			bank_mem[bank_sel][word_idx] <= mem_cmd.wdata;
		end
	end

	// Two register read pipeline
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_stage1 <= '0;
			rd_stage2 <= '0;
		end else begin
			rd_stage1 <= mem_cmd.rd ? bank_mem[bank_sel][word_idx] : '0;
			rd_stage2 <= rd_stage1;
		end
	end

	assign mem_rdata = rd_stage2;

endmodule

// File: hdl/cache_array.sv
`timescale 1ns/10ps

module cache_array
	import cache_pkg::*;
#(
	parameter int  INDEX_BITS = 5,
	localparam int TAG_W      = ADDR_W - INDEX_BITS - OFFSET_BITS,
	localparam int LINES      = 1 << INDEX_BITS
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [INDEX_BITS-1:0] a_index,
	input  logic [1:0]            a_offset,
	input  logic                  a_comp,
	input  logic                  a_write,
	input  logic [DATA_W-1:0]     a_wdata,
	input  logic [TAG_W-1:0]      a_tag_in,
	input  logic [TAG_W-1:0]      req_tag,
	output logic                  hit,
	output logic                  valid,
	output logic                  dirty,
	output logic [TAG_W-1:0]      victim_tag,
	output logic [DATA_W-1:0]     rdata
);

	logic [TAG_W-1:0]       tag_mem  [LINES];
	logic [3:0][DATA_W-1:0] data_mem [LINES];  // Four words per line
	logic [LINES-1:0]       valid_bits;
	logic [LINES-1:0]       dirty_bits;
	logic                   cmp_write;
	logic                   fill_write;
	logic                   fill_last;

	// Status of the addressed line
	assign valid      = valid_bits[a_index];
	assign dirty      = dirty_bits[a_index];
	assign victim_tag = tag_mem[a_index];
	assign hit        = valid && (victim_tag == req_tag);
	assign rdata      = data_mem[a_index][a_offset];

	assign cmp_write  = a_comp & a_write & hit;   // Host write, hits only
	assign fill_write = ~a_comp & a_write;
	assign fill_last  = fill_write & (a_offset == 2'd3);

	always_ff @(posedge clk) begin
		if (cmp_write || fill_write) begin
			data_mem[a_index][a_offset] <= a_wdata;
		end
		if (fill_last) begin
			tag_mem[a_index] <= a_tag_in;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (cmp_write) begin
			dirty_bits[a_index] <= 1'b1;
		end else if (fill_last) begin
			valid_bits[a_index] <= 1'b1;  // Line now matches memory
			dirty_bits[a_index] <= 1'b0;
		end
	end

endmodule

// File: hdl/cache_controller.sv
`timescale 1ns/10ps

module cache_controller
	import cache_pkg::*;
#(
	parameter int  INDEX_BITS = 5,
	localparam int TAG_W      = ADDR_W - INDEX_BITS - OFFSET_BITS
) (
	input  logic                  clk,
	input  logic                  arst_n,
	input  cache_req_t            req,
	input  logic                  hit,
	input  logic                  valid,
	input  logic                  dirty,
	input  logic [TAG_W-1:0]      victim_tag,
	input  logic [DATA_W-1:0]     rdata_arr,
	input  logic [DATA_W-1:0]     mem_rdata,
	output logic                  done,
	output logic [INDEX_BITS-1:0] a_index,
	output logic [1:0]            a_offset,
	output logic                  a_comp,
	output logic                  a_write,
	output logic [DATA_W-1:0]     a_wdata,
	output logic [TAG_W-1:0]      a_tag_in,
	output logic [TAG_W-1:0]      req_tag,
	output mem_cmd_t              mem_cmd
);

	ctrl_state_t           state;
	ctrl_state_t           next_state;
	logic [ADDR_W-1:0]     addr_q;      // Address of the missing request
	logic [ADDR_W-1:0]     line_addr;
	logic [INDEX_BITS-1:0] line_index;
	logic [TAG_W-1:0]      line_tag;
	logic                  access;
	logic [1:0]            mem_word;
	logic                  mem_victim;  // Address memory with the victim tag

	assign access     = req.rd | req.wr;
	assign line_addr  = (state == IDLE) ? req.addr : addr_q;  // Live only in Idle
	assign line_index = line_addr[OFFSET_BITS +: INDEX_BITS];
	assign line_tag   = line_addr[ADDR_W-1 -: TAG_W];

	assign a_index  = line_index;
	assign req_tag  = line_tag;
	assign a_tag_in = addr_q[ADDR_W-1 -: TAG_W];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && next_state != IDLE) begin
			addr_q <= req.addr;
		end
	end

	always_comb begin
		next_state = state;
		done       = 1'b0;
		a_offset   = line_addr[2:1];
		a_comp     = 1'b0;
		a_write    = 1'b0;
		a_wdata    = mem_rdata;  // Fill writes take the returned word
		mem_word   = 2'd0;
		mem_victim = 1'b0;
		mem_cmd    = '0;

		case (state)
		IDLE: begin
			a_comp  = 1'b1;
			a_write = req.wr;
			a_wdata = req.wdata;
			done    = access & hit;
			if (access && !hit) begin
				next_state = (valid && dirty) ? WB0 : FILL_REQ0;
			end
		end
		WB0: begin
			a_offset   = 2'd0;
			mem_word   = 2'd0;
			mem_victim = 1'b1;
			mem_cmd.wr = 1'b1;
			next_state = WB1;
		end
		WB1: begin
			a_offset   = 2'd1;
			mem_word   = 2'd1;
			mem_victim = 1'b1;
			mem_cmd.wr = 1'b1;
			next_state = WB2;
		end
		WB2: begin
			a_offset   = 2'd2;
			mem_word   = 2'd2;
			mem_victim = 1'b1;
			mem_cmd.wr = 1'b1;
			next_state = WB3;
		end
		WB3: begin
			a_offset   = 2'd3;
			mem_word   = 2'd3;
			mem_victim = 1'b1;
			mem_cmd.wr = 1'b1;
			next_state = FILL_REQ0;  // -> Fill after writeback
		end
		FILL_REQ0: begin
			mem_word   = 2'd0;
			mem_cmd.rd = 1'b1;
			next_state = FILL_REQ1;
		end
		FILL_REQ1: begin
			mem_word   = 2'd1;
			mem_cmd.rd = 1'b1;
			next_state = FILL_REQ2_WR0;
		end
		FILL_REQ2_WR0: begin
			mem_word   = 2'd2;
			mem_cmd.rd = 1'b1;
			a_offset   = 2'd0;  // Word 0 returns now
			a_write    = 1'b1;
			next_state = FILL_REQ3_WR1;
		end
		FILL_REQ3_WR1: begin
			mem_word   = 2'd3;
			mem_cmd.rd = 1'b1;
			a_offset   = 2'd1;
			a_write    = 1'b1;
			next_state = FILL_WR2;
		end
		FILL_WR2: begin
			a_offset   = 2'd2;
			a_write    = 1'b1;
			next_state = FILL_WR3;
		end
		FILL_WR3: begin
			a_offset   = 2'd3;
			a_write    = 1'b1;
			next_state = IDLE;  // -> Idle, held request hits
		end
		default: begin
			next_state = IDLE;
		end
		endcase

		mem_cmd.addr  = {(mem_victim ? victim_tag : line_tag), line_index, mem_word, 1'b0};
		mem_cmd.wdata = rdata_arr;
	end

endmodule

// File: hdl/cache_system.sv
`timescale 1ns/10ps

module cache_system
	import cache_pkg::*;
#(
	parameter int  INDEX_BITS = 5,
	localparam int TAG_W      = ADDR_W - INDEX_BITS - OFFSET_BITS
) (
	input  logic              clk,
	input  logic              arst_n,
	input  cache_req_t        req,
	output logic [DATA_W-1:0] rdata,
	output logic              done
);

	logic                  hit;
	logic                  valid;
	logic                  dirty;
	logic [TAG_W-1:0]      victim_tag;
	logic [INDEX_BITS-1:0] a_index;
	logic [1:0]            a_offset;
	logic                  a_comp;
	logic                  a_write;
	logic [DATA_W-1:0]     a_wdata;
	logic [TAG_W-1:0]      a_tag_in;
	logic [TAG_W-1:0]      req_tag;
	mem_cmd_t              mem_cmd;
	logic [DATA_W-1:0]     mem_rdata;

	cache_controller #(
		.INDEX_BITS(INDEX_BITS)
	) u_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.req       (req),
		.hit       (hit),
		.valid     (valid),
		.dirty     (dirty),
		.victim_tag(victim_tag),
		.rdata_arr (rdata),       // Also feeds the writeback data
		.mem_rdata (mem_rdata),
		.done      (done),
		.a_index   (a_index),
		.a_offset  (a_offset),
		.a_comp    (a_comp),
		.a_write   (a_write),
		.a_wdata   (a_wdata),
		.a_tag_in  (a_tag_in),
		.req_tag   (req_tag),
		.mem_cmd   (mem_cmd)
	);

	cache_array #(
		.INDEX_BITS(INDEX_BITS)
	) u_array (
		.clk       (clk),
		.arst_n    (arst_n),
		.a_index   (a_index),
		.a_offset  (a_offset),
		.a_comp    (a_comp),
		.a_write   (a_write),
		.a_wdata   (a_wdata),
		.a_tag_in  (a_tag_in),
		.req_tag   (req_tag),
		.hit       (hit),
		.valid     (valid),
		.dirty     (dirty),
		.victim_tag(victim_tag),
		.rdata     (rdata)
	);

	main_memory u_mem (
		.clk      (clk),
		.arst_n   (arst_n),
		.mem_cmd  (mem_cmd),
		.mem_rdata(mem_rdata)
	);

endmodule

// File: bench/cache_system_tb.sv
`timescale 1ns/10ps

module cache_system_tb
	import cache_pkg::*;
();

	localparam int INDEX_BITS   = 5;
	localparam int TAG_W        = ADDR_W - INDEX_BITS - OFFSET_BITS;
	localparam int LINES        = 1 << INDEX_BITS;
	localparam int CLK_PERIOD   = 4;
	localparam int DIRECTED_OPS = 13;
	localparam int RANDOM_OPS   = 200;
	localparam int NUM_OPS      = DIRECTED_OPS + RANDOM_OPS;
	localparam int MAX_WAIT     = 20;  // Cycles before a request counts as stuck
	localparam int HIT_LAT      = 0;
	localparam int FILL_LAT     = 7;   // Six fill states before the Idle hit
	localparam int EVICT_LAT    = 11;  // Four writeback states ahead of the fill

	logic              clk;
	logic              arst_n;
	cache_req_t        req;
	logic [DATA_W-1:0] rdata;
	logic              done;

	int          data_errors;
	int          latency_errors;
	int          other_errors;
	logic [31:0] rng_state;

	// Reference view of memory filled lazily from the preload rule
	logic [DATA_W-1:0] shadow_mem [logic [ADDR_W-1:0]];
	logic              shadow_valid [LINES];
	logic              shadow_dirty [LINES];
	logic [TAG_W-1:0]  shadow_tag   [LINES];

	cache_system #(
		.INDEX_BITS(INDEX_BITS)
	) u_dut (
		.clk   (clk),
		.arst_n(arst_n),
		.req   (req),
		.rdata (rdata),
		.done  (done)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
		logic [ADDR_W-1:0] a;
		a = {addr[ADDR_W-1:1], 1'b0};
		if (shadow_mem.exists(a)) begin
			return shadow_mem[a];
		end
		return ~a;  // Untouched word still holds its preload value
	endfunction

	function automatic int predict_latency(input logic [ADDR_W-1:0] addr);
		logic [INDEX_BITS-1:0] idx;
		logic [TAG_W-1:0]      tag;
		idx = addr[OFFSET_BITS +: INDEX_BITS];
		tag = addr[ADDR_W-1 -: TAG_W];
		if (shadow_valid[idx] && shadow_tag[idx] == tag) begin
			return HIT_LAT;
		end
		return (shadow_valid[idx] && shadow_dirty[idx]) ? EVICT_LAT : FILL_LAT;
	endfunction

	task automatic update_shadow(input logic is_wr, input logic [ADDR_W-1:0] addr,
	                             input logic [DATA_W-1:0] wdata);
		logic [INDEX_BITS-1:0] idx;
		logic [TAG_W-1:0]      tag;
		idx = addr[OFFSET_BITS +: INDEX_BITS];
		tag = addr[ADDR_W-1 -: TAG_W];
		if (!(shadow_valid[idx] && shadow_tag[idx] == tag)) begin
			shadow_valid[idx] = 1'b1;  // Line refilled clean
			shadow_tag[idx]   = tag;
			shadow_dirty[idx] = 1'b0;
		end
		if (is_wr) begin
			shadow_dirty[idx] = 1'b1;
			shadow_mem[{addr[ADDR_W-1:1], 1'b0}] = wdata;
		end
	endtask

	// Entered and left 1 ns after a rising edge
	task automatic run_access(input logic is_wr, input logic [ADDR_W-1:0] addr,
	                          input logic [DATA_W-1:0] wdata,
	                          output logic [DATA_W-1:0] got, output int cycles);
		ctrl_state_t st;
		req.addr  = addr;
		req.wdata = wdata;
		req.rd    = ~is_wr;
		req.wr    = is_wr;
		cycles    = 0;
		@(negedge clk);
		while (!done && cycles < MAX_WAIT) begin
			cycles++;
			@(negedge clk);
		end
		st = u_dut.u_ctrl.state;
		assert (done) else begin
			$display("Request to address %h never completed, controller stuck in %s",
			         addr, st.name());
			other_errors++;
		end
		got = rdata;  // Sampled mid cycle while done is high
		@(posedge clk);
		#1;
		req = '0;
	endtask

	task automatic check_access(input logic is_wr, input logic [ADDR_W-1:0] addr,
	                            input logic [DATA_W-1:0] wdata, input int want_lat);
		logic [DATA_W-1:0] got;
		logic [DATA_W-1:0] exp_data;
		int                cycles;
		int                exp_lat;
		exp_lat  = predict_latency(addr);
		exp_data = expected_word(addr);
		run_access(is_wr, addr, wdata, got, cycles);
		assert (cycles == exp_lat) else begin
			$display("[FAIL] %0t: access to %h took %0d cycles, line state predicts %0d",
			         $time, addr, cycles, exp_lat);
			latency_errors++;
		end
		if (want_lat >= 0) begin
			assert (cycles == want_lat) else begin
				$display("[FAIL] %0t: access to %h took %0d cycles, expected %0d",
				         $time, addr, cycles, want_lat);
				latency_errors++;
			end
		end
		if (!is_wr) begin
			assert (got == exp_data) else begin
				$display("[FAIL] %0t: read of %h returned %h, expected %h",
				         $time, addr, got, exp_data);
				data_errors++;
			end
		end
		update_shadow(is_wr, addr, wdata);
	endtask

	task automatic cold_read_after_reset();
		assert (done === 1'b0) else begin
			$display("[FAIL] %0t: done was high after reset", $time);
			other_errors++;
		end
		check_access(1'b0, 16'h1230, '0, FILL_LAT);
	endtask

	task automatic repeated_read_hits();
		check_access(1'b0, 16'h1230, '0, HIT_LAT);
		check_access(1'b0, 16'h1236, '0, HIT_LAT);  // Other word of the same line
	endtask

	task automatic write_hit_read_back();
		check_access(1'b1, 16'h1232, 16'hbeef, HIT_LAT);
		check_access(1'b0, 16'h1232, '0, HIT_LAT);
		check_access(1'b0, 16'h1230, '0, HIT_LAT);
		check_access(1'b0, 16'h1234, '0, HIT_LAT);
		check_access(1'b0, 16'h1236, '0, HIT_LAT);
	endtask

	task automatic write_miss_allocate();
		check_access(1'b1, 16'h3378, 16'h5a5a, FILL_LAT);
		check_access(1'b0, 16'h3378, '0, HIT_LAT);
	endtask

	// A and B share index 9 with different tags
	task automatic dirty_line_eviction();
		check_access(1'b1, 16'h2148, 16'hc0de, FILL_LAT);
		check_access(1'b0, 16'h5548, '0, EVICT_LAT);
		check_access(1'b0, 16'h2148, '0, FILL_LAT);  // Data comes back via the writeback
	endtask

	task automatic random_access_mix();
		logic [31:0]           r;
		logic [TAG_W-1:0]      tag;
		logic [INDEX_BITS-1:0] idx;
		logic [ADDR_W-1:0]     addr;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			rng_state = xorshift(rng_state);
			r         = rng_state;
			case (r[1:0])
			2'd0:    tag = TAG_W'(8'h12);
			2'd1:    tag = TAG_W'(8'h21);
			2'd2:    tag = TAG_W'(8'h55);
			default: tag = TAG_W'(8'hc3);
			endcase
			idx  = INDEX_BITS'(6 + r[3:2]);  // Lines 6 to 9
			addr = {tag, idx, r[5:4], 1'b0};
			check_access(r[8], addr, r[31:16], -1);
		end
	endtask

	initial begin
		data_errors    = 0;
		latency_errors = 0;
		other_errors   = 0;
		rng_state      = 32'ha2da7321;
		req            = '0;
		arst_n         = 1'b0;
		for (int i = 0; i < LINES; i++) begin
			shadow_valid[i] = 1'b0;
			shadow_dirty[i] = 1'b0;
			shadow_tag[i]   = '0;
		end
		repeat (2) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(posedge clk);
		#1;

		cold_read_after_reset();
		repeated_read_hits();
		write_hit_read_back();
		write_miss_allocate();
		dirty_line_eviction();
		random_access_mix();

		$display("Errors: data %0d, latency %0d, protocol %0d",
		         data_errors, latency_errors, other_errors);
		if (data_errors + latency_errors + other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Each operation needs at most twelve cycles
	initial begin
		#(NUM_OPS * 12 * CLK_PERIOD + 200);
		$display("Watchdog timeout: the tests did not finish in time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: cache_system.f
hdl/cache_pkg.sv
hdl/main_memory.sv
hdl/cache_array.sv
hdl/cache_controller.sv
hdl/cache_system.sv
bench/cache_system_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_system_tb
FILELIST  ?= cache_system.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fxq "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
